// ==== verilog/game_pkg.sv ====
package game_pkg;

    // ----------------------------------------------------------------------
    // game constants
    // ----------------------------------------------------------------------

    localparam int NUM_TARGETS = 3;
    localparam int START_LIVES = 3;
    localparam int WIN_SCORE   = 3;

    localparam int SCORE_W     = 3;
    localparam int LIVES_W     = 2;

    // ----------------------------------------------------------------------
    // vector types
    // ----------------------------------------------------------------------

    typedef logic [SCORE_W-1:0]     score_t;
    typedef logic [LIVES_W-1:0]     lives_t;

    // one bit per target, the three hearts use the same shape
    typedef logic [NUM_TARGETS-1:0] target_mask_t;

    // ----------------------------------------------------------------------
    // game state machine
    // ----------------------------------------------------------------------

    typedef enum logic [2:0]
    {
        state_start_game  = 3'd0,
        state_start_round = 3'd1,
        state_aim         = 3'd2,
        state_shoot       = 3'd3,
        state_end_round   = 3'd4,
        state_end_game    = 3'd5
    }
    game_state_t;

endpackage

// ==== verilog/game_event_capture.sv ====
`timescale 1ns/10ps

module game_event_capture
(
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   shoot,
    input  logic                   collision,
    input  logic                   collision_bullet,
    input  game_pkg::target_mask_t target_within_screen,
    input  logic                   bullet_within_screen,
    input  logic                   spaceship_within_screen,
    input  logic                   timer_running,

    output logic                   shoot_q,
    output logic                   collision_hit,
    output logic                   bullet_hit,
    output logic                   round_end,
    output logic                   timer_running_q
);

    logic collision_del;
    logic collision_rise;
    logic any_off_screen;

    // a held collision only counts once
    assign collision_rise = collision & ~collision_del;

    // any moving sprite gone from the screen closes the round
    assign any_off_screen = ~(&target_within_screen)
                          | ~bullet_within_screen
                          | ~spaceship_within_screen;

    // ----------------------------------------------------------------------
    // sampled event levels
    // ----------------------------------------------------------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            collision_del   <= 1'b0;
            shoot_q         <= 1'b0;
            collision_hit   <= 1'b0;
            bullet_hit      <= 1'b0;
            round_end       <= 1'b0;
            timer_running_q <= 1'b0;
        end
        else
        begin
            collision_del   <= collision;
            shoot_q         <= shoot;
            collision_hit   <= collision_rise;
            bullet_hit      <= collision_bullet;
            round_end       <= any_off_screen;
            timer_running_q <= timer_running;
        end
    end

endmodule

// ==== verilog/game_master_fsm.sv ====
`timescale 1ns/10ps

module game_master_fsm
(
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  shoot_q,
    input  logic                  collision_hit,
    input  logic                  bullet_hit,
    input  logic                  round_end,
    input  logic                  timer_running_q,

    output game_pkg::game_state_t state,
    output game_pkg::score_t      score,
    output game_pkg::lives_t      lives,
    output logic                  game_won
);

    game_pkg::game_state_t d_state;
    game_pkg::score_t      d_score;
    game_pkg::lives_t      d_lives;
    logic                  d_game_won;

    game_pkg::lives_t      lives_after_hit;
    game_pkg::score_t      score_after_hit;
    game_pkg::game_state_t state_after_hit;

    assign lives_after_hit = lives - 1'b1;
    assign score_after_hit = score + 1'b1;

    // losing the last heart ends the game, otherwise only the round
    assign state_after_hit = (lives_after_hit == '0) ? game_pkg::state_end_game
                                                     : game_pkg::state_end_round;

    // ----------------------------------------------------------------------
    // next state, score and lives
    // ----------------------------------------------------------------------

    always_comb
    begin
        d_state    = state;
        d_score    = score;
        d_lives    = lives;
        d_game_won = game_won;

        case (state)

        game_pkg::state_start_game:
        begin
            d_score    = '0;
            d_lives    = game_pkg::lives_t'(game_pkg::START_LIVES);
            d_game_won = 1'b0;
            d_state    = game_pkg::state_start_round;
        end

        game_pkg::state_start_round:
        begin
            // timer already stopped means the game is over
            if (!timer_running_q)
                d_state = game_pkg::state_end_game;
            else
                d_state = game_pkg::state_aim;
        end

        game_pkg::state_aim:
        begin
            if (collision_hit)
            begin
                d_lives = lives_after_hit;
                d_state = state_after_hit;
            end
            else if (round_end)
            begin
                d_state = game_pkg::state_end_round;
            end
            else if (shoot_q)
            begin
                d_state = game_pkg::state_shoot;
            end
        end

        game_pkg::state_shoot:
        begin
            // a bullet hit wins over a spaceship collision in the same cycle
            if (bullet_hit)
            begin
                d_score = score_after_hit;
                d_state = game_pkg::state_end_round;

                if (score_after_hit == game_pkg::score_t'(game_pkg::WIN_SCORE))
                    d_game_won = 1'b1;
            end
            else if (collision_hit)
            begin
                d_lives = lives_after_hit;
                d_state = state_after_hit;
            end
            else if (round_end)
            begin
                d_state = game_pkg::state_end_round;
            end
        end

        game_pkg::state_end_round:
        begin
            d_state = game_pkg::state_start_round;
        end

        game_pkg::state_end_game:
        begin
            d_state = game_pkg::state_start_game;
        end

        default:
        begin
            d_state = game_pkg::state_start_game;
        end

        endcase
    end

    // ----------------------------------------------------------------------
    // state registers
    // ----------------------------------------------------------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state    <= game_pkg::state_start_game;
            score    <= '0;
            lives    <= game_pkg::lives_t'(game_pkg::START_LIVES);
            game_won <= 1'b0;
        end
        else
        begin
            state    <= d_state;
            score    <= d_score;
            lives    <= d_lives;
            game_won <= d_game_won;
        end
    end

endmodule

// ==== verilog/sprite_command_decode.sv ====
`timescale 1ns/10ps

module sprite_command_decode
(
    input  logic                   clk,
    input  logic                   rst,

    input  game_pkg::game_state_t  state,
    input  game_pkg::lives_t       lives,

    output game_pkg::target_mask_t target_write_xy,
    output game_pkg::target_mask_t target_write_dxy,
    output game_pkg::target_mask_t target_enable_update,

    output logic                   bullet_write_xy,
    output logic                   bullet_write_dxy,
    output logic                   bullet_enable_update,

    output logic                   spaceship_write_xy,
    output logic                   spaceship_write_dxy,
    output logic                   spaceship_enable_update,

    output logic                   bullet_rgb_en,
    output logic                   timer_start,
    output game_pkg::target_mask_t heart_rgb_en
);

    game_pkg::target_mask_t d_target_write_xy;
    game_pkg::target_mask_t d_target_write_dxy;
    game_pkg::target_mask_t d_target_enable_update;
    game_pkg::target_mask_t d_heart_rgb_en;

    logic d_bullet_write_xy;
    logic d_spaceship_write_xy;
    logic d_moving;
    logic d_bullet_rgb_en;
    logic d_timer_start;

    // ----------------------------------------------------------------------
    // strobes per state
    // ----------------------------------------------------------------------

    always_comb
    begin
        d_target_write_xy      = '0;
        d_target_write_dxy     = '0;
        d_target_enable_update = '0;
        d_bullet_write_xy      = 1'b0;
        d_spaceship_write_xy   = 1'b0;
        d_moving               = 1'b0;
        d_bullet_rgb_en        = 1'b0;
        d_timer_start          = 1'b0;

        case (state)
        game_pkg::state_start_game:
        begin
            d_timer_start = 1'b1;
        end

        // place everything for a new round
        game_pkg::state_start_round:
        begin
            d_target_write_xy    = '1;
            d_target_write_dxy   = '1;
            d_bullet_write_xy    = 1'b1;
            d_spaceship_write_xy = 1'b1;
        end

        game_pkg::state_aim:
        begin
            d_target_enable_update = '1;
            d_moving               = 1'b1;
        end

        game_pkg::state_shoot:
        begin
            d_target_enable_update = '1;
            d_moving               = 1'b1;
            d_bullet_rgb_en        = 1'b1;
        end

        default:
        begin
            d_timer_start = 1'b0;
        end
        endcase
    end

    // bit 0 is heart 3, so the hearts go out from heart 1 upward
    always_comb
    begin
        for (int i = 0; i < game_pkg::NUM_TARGETS; i++)
            d_heart_rgb_en[i] = (int'(lives) > i);
    end

    // ----------------------------------------------------------------------
    // output registers
    // ----------------------------------------------------------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            target_write_xy         <= '0;
            target_write_dxy        <= '0;
            target_enable_update    <= '0;
            bullet_write_xy         <= 1'b0;
            bullet_write_dxy        <= 1'b0;
            bullet_enable_update    <= 1'b0;
            spaceship_write_xy      <= 1'b0;
            spaceship_write_dxy     <= 1'b0;
            spaceship_enable_update <= 1'b0;
            bullet_rgb_en           <= 1'b0;
            timer_start             <= 1'b0;
            heart_rgb_en            <= '0;
        end
        else
        begin
            target_write_xy         <= d_target_write_xy;
            target_write_dxy        <= d_target_write_dxy;
            target_enable_update    <= d_target_enable_update;
            bullet_write_xy         <= d_bullet_write_xy;
            bullet_write_dxy        <= d_moving;
            bullet_enable_update    <= d_moving;
            spaceship_write_xy      <= d_spaceship_write_xy;
            spaceship_write_dxy     <= d_moving;
            spaceship_enable_update <= d_moving;
            bullet_rgb_en           <= d_bullet_rgb_en;
            timer_start             <= d_timer_start;
            heart_rgb_en            <= d_heart_rgb_en;
        end
    end

endmodule

// ==== verilog/game_master_top.sv ====
`timescale 1ns/10ps

module game_master_top
(
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   shoot,
    input  logic                   collision,
    input  logic                   collision_bullet,
    input  game_pkg::target_mask_t target_within_screen,
    input  logic                   bullet_within_screen,
    input  logic                   spaceship_within_screen,
    input  logic                   timer_running,

    output game_pkg::game_state_t  state,
    output game_pkg::score_t       score,
    output game_pkg::lives_t       lives,
    output logic                   game_won,

    output game_pkg::target_mask_t target_write_xy,
    output game_pkg::target_mask_t target_write_dxy,
    output game_pkg::target_mask_t target_enable_update,
    output logic                   bullet_write_xy,
    output logic                   bullet_write_dxy,
    output logic                   bullet_enable_update,
    output logic                   spaceship_write_xy,
    output logic                   spaceship_write_dxy,
    output logic                   spaceship_enable_update,
    output logic                   bullet_rgb_en,
    output logic                   timer_start,
    output game_pkg::target_mask_t heart_rgb_en
);

    // stage 1 to stage 2
    logic shoot_q;
    logic collision_hit;
    logic bullet_hit;
    logic round_end;
    logic timer_running_q;

    // ----------------------------------------------------------------------
    // pipeline stages
    // ----------------------------------------------------------------------

    game_event_capture u_capture
    (
        .clk                     (clk),
        .rst                     (rst),
        .shoot                   (shoot),
        .collision               (collision),
        .collision_bullet        (collision_bullet),
        .target_within_screen    (target_within_screen),
        .bullet_within_screen    (bullet_within_screen),
        .spaceship_within_screen (spaceship_within_screen),
        .timer_running           (timer_running),
        .shoot_q                 (shoot_q),
        .collision_hit           (collision_hit),
        .bullet_hit              (bullet_hit),
        .round_end               (round_end),
        .timer_running_q         (timer_running_q)
    );

    game_master_fsm u_fsm
    (
        .clk             (clk),
        .rst             (rst),
        .shoot_q         (shoot_q),
        .collision_hit   (collision_hit),
        .bullet_hit      (bullet_hit),
        .round_end       (round_end),
        .timer_running_q (timer_running_q),
        .state           (state),
        .score           (score),
        .lives           (lives),
        .game_won        (game_won)
    );

    sprite_command_decode u_decode
    (
        .clk                     (clk),
        .rst                     (rst),
        .state                   (state),
        .lives                   (lives),
        .target_write_xy         (target_write_xy),
        .target_write_dxy        (target_write_dxy),
        .target_enable_update    (target_enable_update),
        .bullet_write_xy         (bullet_write_xy),
        .bullet_write_dxy        (bullet_write_dxy),
        .bullet_enable_update    (bullet_enable_update),
        .spaceship_write_xy      (spaceship_write_xy),
        .spaceship_write_dxy     (spaceship_write_dxy),
        .spaceship_enable_update (spaceship_enable_update),
        .bullet_rgb_en           (bullet_rgb_en),
        .timer_start             (timer_start),
        .heart_rgb_en            (heart_rgb_en)
    );

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen
(
    output logic clk,
    output logic rst
);

    localparam int HALF_PERIOD  = 2;
    localparam int RESET_CYCLES = 3;

    initial
    begin
        clk = 1'b0;
        forever
            #HALF_PERIOD clk = ~clk;
    end

    // reset drops on a falling edge, away from the sampling edge
    initial
    begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// ==== verification/tb_game_master.sv ====
`timescale 1ns/10ps

module tb_game_master;

    // columns per step line of the input file
    localparam int FIELDS    = 13;
    localparam int MAX_STEPS = 64;
    localparam int MARGIN    = 50;

    // strobe words per decoded state, laid out as in strobe_word
    localparam logic [16:0] START_GAME_STROBES  = 17'b000_000_000_000_000_0_1;
    localparam logic [16:0] START_ROUND_STROBES = 17'b111_111_000_100_100_0_0;
    localparam logic [16:0] SHOOT_STROBES       = 17'b000_000_111_011_011_1_0;

    logic clk;
    logic rst;

    logic                   shoot;
    logic                   collision;
    logic                   collision_bullet;
    game_pkg::target_mask_t target_within_screen;
    logic                   bullet_within_screen;
    logic                   spaceship_within_screen;
    logic                   timer_running;

    game_pkg::game_state_t  state;
    game_pkg::score_t       score;
    game_pkg::lives_t       lives;
    logic                   game_won;
    game_pkg::target_mask_t target_write_xy;
    game_pkg::target_mask_t target_write_dxy;
    game_pkg::target_mask_t target_enable_update;
    logic                   bullet_write_xy;
    logic                   bullet_write_dxy;
    logic                   bullet_enable_update;
    logic                   spaceship_write_xy;
    logic                   spaceship_write_dxy;
    logic                   spaceship_enable_update;
    logic                   bullet_rgb_en;
    logic                   timer_start;
    game_pkg::target_mask_t heart_rgb_en;

    logic [7:0] step_mem [0:FIELDS*MAX_STEPS-1];

    int   value_errors = 0;
    int   event_errors = 0;
    int   cycle_count  = 0;
    int   cycle_limit  = 0;

    // strobe patterns seen while a step runs
    logic seen_timer_start;
    logic seen_bullet_rgb;
    logic seen_target_xy;

    tb_clock_gen u_clock_gen
    (
        .clk (clk),
        .rst (rst)
    );

    game_master_top u_dut
    (
        .clk                     (clk),
        .rst                     (rst),
        .shoot                   (shoot),
        .collision               (collision),
        .collision_bullet        (collision_bullet),
        .target_within_screen    (target_within_screen),
        .bullet_within_screen    (bullet_within_screen),
        .spaceship_within_screen (spaceship_within_screen),
        .timer_running           (timer_running),
        .state                   (state),
        .score                   (score),
        .lives                   (lives),
        .game_won                (game_won),
        .target_write_xy         (target_write_xy),
        .target_write_dxy        (target_write_dxy),
        .target_enable_update    (target_enable_update),
        .bullet_write_xy         (bullet_write_xy),
        .bullet_write_dxy        (bullet_write_dxy),
        .bullet_enable_update    (bullet_enable_update),
        .spaceship_write_xy      (spaceship_write_xy),
        .spaceship_write_dxy     (spaceship_write_dxy),
        .spaceship_enable_update (spaceship_enable_update),
        .bullet_rgb_en           (bullet_rgb_en),
        .timer_start             (timer_start),
        .heart_rgb_en            (heart_rgb_en)
    );

    // ----------------------------------------------------------------------
    // checks
    // ----------------------------------------------------------------------

    // strobe outputs as one word, target groups first and timer_start last
    function automatic logic [16:0] strobe_word();
        return {target_write_xy, target_write_dxy, target_enable_update,
                bullet_write_xy, bullet_write_dxy, bullet_enable_update,
                spaceship_write_xy, spaceship_write_dxy, spaceship_enable_update,
                bullet_rgb_en, timer_start};
    endfunction

    task automatic compare_value(input string name, input int expected, input int actual);
        assert (actual == expected)
        else
        begin
            value_errors++;
            $display("Fail at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    task automatic require_seen(input int step, input logic wanted, input logic seen,
                                input string name);
        assert (!wanted || seen)
        else
        begin
            event_errors++;
            $display("Step %0d at %0t: %s never appeared during the step", step, $time, name);
        end
    endtask

    // ----------------------------------------------------------------------
    // one line of the input file
    // ----------------------------------------------------------------------

    task automatic apply_step(input int step);
        int          base;
        int          count;
        logic [16:0] strobes;
        base  = step * FIELDS;
        count = int'(step_mem[base]);

        shoot                   = step_mem[base+1][0];
        collision               = step_mem[base+2][0];
        collision_bullet        = step_mem[base+3][0];
        target_within_screen    = step_mem[base+4][game_pkg::NUM_TARGETS-1:0];
        bullet_within_screen    = step_mem[base+5][0];
        spaceship_within_screen = step_mem[base+6][0];
        timer_running           = step_mem[base+7][0];

        seen_timer_start = 1'b0;
        seen_bullet_rgb  = 1'b0;
        seen_target_xy   = 1'b0;

        repeat (count)
        begin
            @(negedge clk);
            strobes          = strobe_word();
            seen_timer_start = seen_timer_start | (strobes == START_GAME_STROBES);
            seen_bullet_rgb  = seen_bullet_rgb | (strobes == SHOOT_STROBES);
            seen_target_xy   = seen_target_xy | (strobes == START_ROUND_STROBES);
        end

        compare_value("score", int'(step_mem[base+8]), int'(score));
        compare_value("lives", int'(step_mem[base+9]), int'(lives));
        compare_value("game_won", int'(step_mem[base+10]), int'(game_won));
        compare_value("heart_rgb_en", int'(step_mem[base+11]), int'(heart_rgb_en));

        require_seen(step, step_mem[base+12][0], seen_timer_start, "start_game strobes");
        require_seen(step, step_mem[base+12][1], seen_bullet_rgb, "shoot strobes");
        require_seen(step, step_mem[base+12][2], seen_target_xy, "start_round strobes");
    endtask

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------

    initial
    begin
        int step;
        int num_steps;
        int total_cycles;

        shoot                   = 1'b0;
        collision               = 1'b0;
        collision_bullet        = 1'b0;
        target_within_screen    = '1;
        bullet_within_screen    = 1'b1;
        spaceship_within_screen = 1'b1;
        timer_running           = 1'b1;

        $readmemh("verification/game_input.txt", step_mem);

        // a count of zero marks the end of the steps
        total_cycles = 0;
        for (step = 0; step < MAX_STEPS; step++)
        begin
            if (step_mem[step*FIELDS] == 8'h00)
                break;
            total_cycles += int'(step_mem[step*FIELDS]);
        end
        num_steps   = step;
        cycle_limit = total_cycles + MARGIN;

        assert (num_steps > 0)
        else
        begin
            event_errors++;
            $display("The input file holds no steps");
        end

        @(negedge rst);

        compare_value("state", int'(game_pkg::state_start_game), int'(state));
        compare_value("score", 0, int'(score));
        compare_value("lives", game_pkg::START_LIVES, int'(lives));
        compare_value("sprite strobes", 0, int'(strobe_word()));

        for (step = 0; step < num_steps; step++)
            apply_step(step);

        $display("Errors: %0d value mismatches, %0d missing events",
                 value_errors, event_errors);
        if (value_errors == 0 && event_errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

    // run limit from the total length of the steps
    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit)
        begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Verification failed");
            $finish;
        end
    end

endmodule

// ==== verification/game_input.txt ====
// cnt shoot coll bhit targets bullet_in ship_in timer | score lives won hearts seen
// seen: bit 0 timer_start, bit 1 bullet_rgb_en, bit 2 target_write_xy
04 0 0 0 7 1 1 1  0 3 0 7 1
// three hits, shoot first and then the bullet
04 1 0 0 7 1 1 1  0 3 0 7 2
04 0 0 1 7 1 1 1  1 3 0 7 4
04 1 0 0 7 1 1 1  1 3 0 7 2
04 0 0 1 7 1 1 1  2 3 0 7 4
04 1 0 0 7 1 1 1  2 3 0 7 2
04 0 0 1 7 1 1 1  3 3 1 7 4
// held collisions, one life each
06 0 1 0 7 1 1 1  3 2 1 3 4
04 0 0 0 7 1 1 1  3 2 1 3 0
04 0 1 0 7 1 1 1  3 1 1 1 4
04 0 0 0 7 1 1 1  3 1 1 1 0
06 0 1 0 7 1 1 1  0 3 0 7 1
04 0 0 0 7 1 1 1  0 3 0 7 0
// sprites leaving the screen while aiming
04 0 0 0 6 1 1 1  0 3 0 7 4
04 0 0 0 7 1 1 1  0 3 0 7 4
04 1 0 0 7 1 1 1  0 3 0 7 2
04 0 0 1 7 1 1 1  1 3 0 7 4
04 0 0 0 7 0 1 1  1 3 0 7 4
04 0 0 0 7 1 1 1  1 3 0 7 4
04 0 0 0 7 1 0 1  1 3 0 7 4
04 0 0 0 7 1 1 1  1 3 0 7 4
// timer stopped, game restarts at every round start
04 1 0 0 7 1 1 0  1 3 0 7 2
06 0 0 1 7 1 1 0  0 3 0 7 1
06 0 0 0 7 1 1 0  0 3 0 7 1
06 0 0 0 7 1 1 0  0 3 0 7 1
06 0 0 0 7 1 1 1  0 3 0 7 4
04 1 0 0 7 1 1 1  0 3 0 7 2
04 0 0 1 7 1 1 1  1 3 0 7 4
// end of steps
00 0 0 0 0 0 0 0  0 0 0 0 0

// ==== tb.f ====
verilog/game_pkg.sv
verilog/game_event_capture.sv
verilog/game_master_fsm.sv
verilog/sprite_command_decode.sv
verilog/game_master_top.sv
verification/tb_clock_gen.sv
verification/tb_game_master.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the game master testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f \
    --top-module tb_game_master -o tb_game_master

output=$(./obj_dir/tb_game_master)
echo "$output"

if echo "$output" | grep -q "^Verification passed$"
then
    exit 0
fi
exit 1
